// File: source/loader_macros.svh
`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// clocks per bit period
// 16 keeps simulation short, use 868 for 100 MHz at 115200 baud
`define LOADER_CLKS_PER_BIT 16

// boot memory depth in words
`define LOADER_MAX_WORDS 16

// word address width, must cover LOADER_MAX_WORDS
`define LOADER_ADDR_W 4

// idle bit periods after the last byte before the load ends
`define LOADER_MAX_IDLE 15

`endif

// File: source/uart_pkg.sv
package uart_pkg;

    // one received byte
    typedef logic [7:0] byte_t;

    // receiver states
    // st_start waits half a bit to recheck the start bit
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_start = 2'd1,
        st_data  = 2'd2,
        st_stop  = 2'd3
    } rx_state_t;

endpackage

// File: source/mem_pkg.sv
`include "loader_macros.svh"

package mem_pkg;

    // one boot memory word
    typedef logic [31:0] word_t;

    // word address into the boot memory
    typedef logic [`LOADER_ADDR_W-1:0] addr_t;

    // assembled word, filled byte by byte and stored as a whole
    // lane 0 is bits 7:0, so bytes land little-endian
    typedef union packed {
        word_t                 word;
        uart_pkg::byte_t [3:0] lanes;
    } word_u;

endpackage

// File: source/uart_rx.sv
`timescale 1ns/1ps
`include "loader_macros.svh"

module uart_rx (
    input  logic            clk,
    input  logic            rst,
    input  logic            rx,
    output uart_pkg::byte_t byte_data,
    output logic            byte_valid,
    output logic            busy
);

    localparam int clks_per_bit = `LOADER_CLKS_PER_BIT;
    localparam int half_bit     = clks_per_bit / 2;
    localparam int cnt_w        = $clog2(clks_per_bit);

    logic [2:0]          rx_sync;
    logic                start_edge;
    logic [cnt_w-1:0]    baud_cnt;
    logic                half_end;
    logic                baud_end;
    logic [2:0]          bit_cnt;
    uart_pkg::rx_state_t state;
    uart_pkg::byte_t     shift_reg;

    // three stage synchroniser, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync <= 3'b111;
        end else begin
            rx_sync <= {rx_sync[1:0], rx};
        end
    end

    // falling edge between the last two stages
    assign start_edge = rx_sync[2] & ~rx_sync[1];

    assign half_end = baud_cnt == cnt_w'(half_bit - 1);
    assign baud_end = baud_cnt == cnt_w'(clks_per_bit - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= uart_pkg::st_idle;
        end else begin
            case (state)
                uart_pkg::st_idle: begin
                    if (start_edge) begin
                        state <= uart_pkg::st_start;
                    end
                end
                uart_pkg::st_start: begin
                    // a glitch shorter than half a bit is dropped here
                    if (half_end) begin
                        state <= rx_sync[1] ? uart_pkg::st_idle : uart_pkg::st_data;
                    end
                end
                uart_pkg::st_data: begin
                    if (baud_end && bit_cnt == 3'd7) begin
                        state <= uart_pkg::st_stop;
                    end
                end
                uart_pkg::st_stop: begin
                    // back to idle mid stop bit, ready for the next edge
                    if (baud_end) begin
                        state <= uart_pkg::st_idle;
                    end
                end
                default: begin
                    state <= uart_pkg::st_idle;
                end
            endcase
        end
    end

    // from the half-bit point on, baud_end lands mid bit
    always_ff @(posedge clk) begin
        if (rst) begin
            baud_cnt <= '0;
        end else if (state == uart_pkg::st_idle || baud_end) begin
            baud_cnt <= '0;
        end else if (state == uart_pkg::st_start && half_end) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt <= 3'd0;
        end else if (state != uart_pkg::st_data) begin
            bit_cnt <= 3'd0;
        end else if (baud_end) begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    // lsb first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == uart_pkg::st_data && baud_end) begin
            shift_reg <= {rx_sync[1], shift_reg[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= state == uart_pkg::st_stop && baud_end;
        end
    end

    assign byte_data = shift_reg;
    assign busy      = state != uart_pkg::st_idle;

endmodule

// File: source/idle_timer.sv
`timescale 1ns/1ps
`include "loader_macros.svh"

module idle_timer (
    input  logic clk,
    input  logic rst,
    input  logic busy,
    input  logic byte_valid,
    output logic timeout
);

    localparam int clks_per_bit = `LOADER_CLKS_PER_BIT;
    localparam int max_idle     = `LOADER_MAX_IDLE;
    localparam int pre_w        = $clog2(clks_per_bit);
    localparam int idle_w       = $clog2(max_idle + 1);

    logic              armed;
    logic [pre_w-1:0]  prescale;
    logic              bit_tick;
    logic [idle_w-1:0] idle_cnt;

    assign bit_tick = prescale == pre_w'(clks_per_bit - 1);

    // no timeout until the first byte has arrived
    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (byte_valid) begin
            armed <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || busy || !armed || bit_tick) begin
            prescale <= '0;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // saturates at the limit
    always_ff @(posedge clk) begin
        if (rst || busy || !armed) begin
            idle_cnt <= '0;
        end else if (bit_tick && idle_cnt != idle_w'(max_idle)) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    assign timeout = idle_cnt == idle_w'(max_idle);

endmodule

// File: source/word_packer.sv
`timescale 1ns/1ps
`include "loader_macros.svh"

module word_packer (
    input  logic            clk,
    input  logic            rst,
    input  uart_pkg::byte_t byte_data,
    input  logic            byte_valid,
    input  logic            timeout,
    output logic            mem_we,
    output mem_pkg::addr_t  mem_addr,
    output mem_pkg::word_t  mem_wdata,
    output logic            done
);

    localparam mem_pkg::addr_t last_addr = mem_pkg::addr_t'(`LOADER_MAX_WORDS - 1);

    mem_pkg::word_u word_buf;
    logic [1:0]     lane;
    logic           take_byte;
    logic           last_write;

    assign last_write = mem_we && mem_addr == last_addr;

    // bytes after done are dropped
    assign take_byte = byte_valid && !done;

    always_ff @(posedge clk) begin
        if (take_byte) begin
            word_buf.lanes[lane] <= byte_data;
        end
    end

    // write strobe follows the lane 3 byte by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            lane   <= 2'd0;
            mem_we <= 1'b0;
        end else begin
            mem_we <= take_byte && lane == 2'd3;
            if (take_byte) begin
                lane <= lane + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_addr <= '0;
        end else if (mem_we) begin
            mem_addr <= mem_addr + 1'b1;
        end
    end

    // sticky until reset
    // a pending partial word is lost on timeout
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (last_write || timeout) begin
            done <= 1'b1;
        end
    end

    assign mem_wdata = word_buf.word;

endmodule

// File: source/boot_mem.sv
`timescale 1ns/1ps
`include "loader_macros.svh"

module boot_mem (
    input  logic           clk,
    input  logic           we,
    input  mem_pkg::addr_t waddr,
    input  mem_pkg::word_t wdata,
    input  mem_pkg::addr_t rd_addr,
    output mem_pkg::word_t rd_data
);

    mem_pkg::word_t mem [`LOADER_MAX_WORDS];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: source/boot_loader.sv
`timescale 1ns/1ps

module boot_loader (
    input  logic           clk,
    input  logic           rst,
    input  logic           rx,
    input  mem_pkg::addr_t rd_addr,
    output mem_pkg::word_t rd_data,
    output logic           done
);

    uart_pkg::byte_t byte_data;
    logic            byte_valid;
    logic            busy;
    logic            timeout;
    logic            mem_we;
    mem_pkg::addr_t  mem_addr;
    mem_pkg::word_t  mem_wdata;

    uart_rx rx0 (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .busy       (busy)
    );

    idle_timer timer0 (
        .clk        (clk),
        .rst        (rst),
        .busy       (busy),
        .byte_valid (byte_valid),
        .timeout    (timeout)
    );

    word_packer packer0 (
        .clk        (clk),
        .rst        (rst),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .timeout    (timeout),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .done       (done)
    );

    boot_mem mem0 (
        .clk     (clk),
        .we      (mem_we),
        .waddr   (mem_addr),
        .wdata   (mem_wdata),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: tb/boot_loader_assertions.sv
`timescale 1ns/1ps

module boot_loader_assertions (
    input logic           clk,
    input logic           rst,
    input logic           mem_we,
    input mem_pkg::addr_t mem_addr,
    input logic           done
);

    // one strobe per assembled word
    no_double_write: assert property (
        @(posedge clk) disable iff (rst) mem_we |=> !mem_we
    ) else $error("mem_we high for two cycles in a row");

    // done only clears through reset
    done_sticky: assert property (
        @(posedge clk) disable iff (rst) done |=> done
    ) else $error("done fell without a reset");

    no_write_after_done: assert property (
        @(posedge clk) disable iff (rst) done |-> !mem_we
    ) else $error("memory write while done is high");

    // wraps past the last word
    addr_step: assert property (
        @(posedge clk) disable iff (rst)
        mem_we |=> mem_addr == mem_pkg::addr_t'($past(mem_addr) + 1'b1)
    ) else $error("write address did not advance by one");

endmodule

bind word_packer boot_loader_assertions asrt0 (
    .clk      (clk),
    .rst      (rst),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .done     (done)
);

// File: tb/boot_loader_tb.sv
`timescale 1ns/1ps
`include "loader_macros.svh"

module boot_loader_tb;

    localparam int num_tests = 6;
    localparam int bit_clks  = `LOADER_CLKS_PER_BIT;
    localparam int max_words = `LOADER_MAX_WORDS;
    localparam int max_idle  = `LOADER_MAX_IDLE;

    logic           clk;
    logic           rst;
    logic           rx;
    mem_pkg::addr_t rd_addr;
    mem_pkg::word_t rd_data;
    logic           done;

    // stimulus table, one column per field
    string test_name  [num_tests] = '{"exact_fill", "timeout_words", "partial_drop",
                                      "overflow", "no_early_timeout", "bit_patterns"};
    int    num_bytes  [num_tests] = '{64, 8, 6, 70, 4, 4};
    bit    use_random [num_tests] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
    bit    idle_first [num_tests] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    int    exp_words  [num_tests] = '{16, 2, 1, 16, 1, 1};

    logic [7:0] fixed_bytes [4] = '{8'h00, 8'hFF, 8'h55, 8'hAA};

    // memory is not reset, so contents carry over between tests
    mem_pkg::word_t exp_mem [max_words];
    bit             known   [max_words];
    logic [7:0]     sent    [$];
    int             write_count;

    boot_loader dut0 (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // write strobes seen at the memory port
    always @(posedge clk) begin
        if (rst) begin
            write_count <= 0;
        end else if (dut0.mem_we) begin
            write_count <= write_count + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        rx  = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    // 8N1 frame, lsb first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (bit_clks) @(negedge clk);
        end
    endtask

    task automatic hold_idle(input string name, input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            check_value({name, " done before first byte"}, 32'd0, {31'd0, done});
        end
    endtask

    task automatic wait_done(input string name, input int limit);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("timed out waiting for done in test %s", name);
            $display("Test FAILED");
            $fatal(1, "done wait expired");
        end
    endtask

    // little-endian packing, byte 0 in bits 7:0
    task automatic update_model(input int words);
        for (int w = 0; w < words; w++) begin
            exp_mem[w] = {sent[4*w+3], sent[4*w+2], sent[4*w+1], sent[4*w]};
            known[w]   = 1'b1;
        end
    endtask

    task automatic read_back(input string name);
        for (int a = 0; a < max_words; a++) begin
            if (known[a]) begin
                rd_addr = mem_pkg::addr_t'(a);
                @(negedge clk);
                check_value($sformatf("%s word %0d", name, a), exp_mem[a], rd_data);
            end
        end
    endtask

    initial begin
        void'($urandom(37863));
        rst     = 1'b1;
        rx      = 1'b1;
        rd_addr = '0;
        for (int a = 0; a < max_words; a++) begin
            known[a] = 1'b0;
        end

        for (int t = 0; t < num_tests; t++) begin
            apply_reset();
            if (idle_first[t]) begin
                hold_idle(test_name[t], (2 * max_idle + 2) * bit_clks);
            end
            sent.delete();
            for (int i = 0; i < num_bytes[t]; i++) begin
                if (use_random[t]) begin
                    sent.push_back(8'($urandom));
                end else begin
                    sent.push_back(fixed_bytes[i % 4]);
                end
                send_byte(sent[i]);
            end
            // idle limit plus a few bit periods of margin
            wait_done(test_name[t], (max_idle + 4) * bit_clks);
            check_value({test_name[t], " write count"}, exp_words[t], write_count);
            update_model(exp_words[t]);
            read_back(test_name[t]);
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/uart_pkg.sv
source/mem_pkg.sv
source/uart_rx.sv
source/idle_timer.sv
source/word_packer.sv
source/boot_mem.sv
source/boot_loader.sv
tb/boot_loader_assertions.sv
tb/boot_loader_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = boot_loader_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
